// ==== Makefile ====
# Verilator build and run of the mailbox testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fail when the log reports failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -sv --top-module tb_top -f tb.f --Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi
	@grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== design/mailbox_ctrl.sv ====
/* mailbox transaction FSM; serves one read or write at a time, decodes the
   register map, drives table ops and memory accesses, raises irq events */
`timescale 1ns/1ps
`default_nettype none

module mailbox_ctrl import mailbox_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_s_awvalid,
  output logic  o_s_awready,
  input  addr_t i_s_awaddr,
  input  fn_t   i_s_awuser,
  input  logic  i_s_wvalid,
  output logic  o_s_wready,
  input  data_t i_s_wdata,
  output logic  o_s_bvalid,
  input  logic  i_s_bready,
  output resp_e o_s_bresp,
  input  logic  i_s_arvalid,
  output logic  o_s_arready,
  input  addr_t i_s_araddr,
  input  fn_t   i_s_aruser,
  output logic  o_s_rvalid,
  input  logic  i_s_rready,
  output data_t o_s_rdata,
  output resp_e o_s_rresp,
  mailbox_msg_mem_if.ctrl mem,
  mailbox_fn_regs_if.ctrl regs,
  output logic  o_irq_vld,
  output fn_t   o_irq_fn,
  input  logic  i_irq_ack
);

  typedef enum logic [8:0] {
    ST_IDLE    = 9'b000000001,
    ST_ADDR    = 9'b000000010,
    ST_DEC     = 9'b000000100,
    ST_RD_WAIT = 9'b000001000,
    ST_RD_RESP = 9'b000010000,
    ST_WR_DATA = 9'b000100000,
    ST_EXEC    = 9'b001000000,
    ST_WR_RESP = 9'b010000000,
    ST_IRQ     = 9'b100000000
  } state_e;

  state_e               state;
  state_e               state_nxt;
  logic                 rd_q;
  logic                 notify_q;
  addr_t                addr_q;
  fn_t                  fn_q;
  data_t                wdata_q;
  data_t                rdata_q;
  resp_e                rresp_q;
  resp_e                bresp_q;
  logic                 pick_rd;
  logic                 is_status;
  logic                 is_cmd;
  logic                 is_target;
  logic                 is_irq_en;
  logic                 is_msg;
  logic [MSG_IDX_W-1:0] msg_idx;
  logic                 rd_done;
  data_t                rdata_c;
  resp_e                rresp_c;
  cmd_e                 cmd_c;
  fn_op_e               op_c;
  resp_e                bresp_c;
  logic                 mem_we_c;

  ////////////////////////////////////////
  // FSM
  // on a tie the kind not served last wins; rd_q also marks the current kind
  assign pick_rd = i_s_arvalid & (~i_s_awvalid | ~rd_q);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      rd_q  <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ST_IDLE && (i_s_awvalid || i_s_arvalid)) begin
        rd_q <= pick_rd;
      end
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:    if (i_s_awvalid || i_s_arvalid) state_nxt = ST_ADDR;
      ST_ADDR:    state_nxt = ST_DEC;
      ST_DEC:     state_nxt = rd_q ? ST_RD_WAIT : ST_WR_DATA;
      ST_RD_WAIT: if (rd_done) state_nxt = ST_RD_RESP;
      ST_RD_RESP: if (i_s_rready) state_nxt = ST_IDLE;
      ST_WR_DATA: if (i_s_wvalid) state_nxt = ST_EXEC;
      ST_EXEC:    state_nxt = ST_WR_RESP;
      ST_WR_RESP: begin
        if (i_s_bready) begin
          state_nxt = (notify_q && regs.notify_en) ? ST_IRQ : ST_IDLE;
        end
      end
      ST_IRQ:     if (i_irq_ack) state_nxt = ST_IDLE;
      default:    state_nxt = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // address, caller and write data capture
  always_ff @(posedge clk) begin
    if (state == ST_ADDR) begin
      addr_q <= rd_q ? i_s_araddr : i_s_awaddr;
      fn_q   <= rd_q ? i_s_aruser : i_s_awuser;
    end
    if (state == ST_WR_DATA && i_s_wvalid) begin
      wdata_q <= i_s_wdata;
    end
  end

  // word aligned addresses only
  assign is_status = (addr_q == STATUS_A);
  assign is_cmd    = (addr_q == CMD_A);
  assign is_target = (addr_q == TARGET_A);
  assign is_irq_en = (addr_q == IRQ_EN_A);
  assign is_msg    = (addr_q >= MSG_BASE_A) && (addr_q < MSG_BASE_A + 4 * MSG_WORDS) &&
                     (addr_q[1:0] == 2'b00);
  assign msg_idx   = addr_q[MSG_IDX_W+1:2];

  ////////////////////////////////////////
  // read path
  // reads come from the caller's own buffer; CMD_A is write only
  assign mem.re      = (state == ST_DEC) & rd_q & is_msg;
  assign mem.rd_addr = '{fn: fn_q, idx: msg_idx};
  assign rd_done     = is_msg ? mem.rvalid : 1'b1;

  always_comb begin
    rdata_c = '0;
    rresp_c = RESP_OKAY;
    if (is_status) begin
      rdata_c[1:0] = {regs.cur_out_pend, regs.cur_in_pend};
    end else if (is_target) begin
      rdata_c[FN_W-1:0] = regs.cur_target;
    end else if (is_irq_en) begin
      rdata_c[0] = regs.cur_irq_en;
    end else if (is_msg) begin
      rdata_c = regs.cur_in_pend ? mem.rdata : '0;
    end else begin
      rresp_c = RESP_DECERR;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_RD_WAIT && rd_done) begin
      rdata_q <= rdata_c;
      rresp_q <= rresp_c;
    end
  end

  ////////////////////////////////////////
  // write execution takes one cycle in ST_EXEC
  assign cmd_c = cmd_e'(wdata_q[$bits(cmd_e)-1:0]);

  always_comb begin
    op_c     = FN_OP_NONE;
    bresp_c  = RESP_OKAY;
    mem_we_c = 1'b0;
    if (state == ST_EXEC) begin
      if (is_cmd) begin
        if (cmd_c == CMD_SEND && !regs.tgt_in_pend) begin
          op_c = FN_OP_SEND;
        end else if (cmd_c == CMD_RCV && regs.cur_in_pend) begin
          op_c = FN_OP_RCV;
        end else begin
          bresp_c = RESP_SLVERR;
        end
      end else if (is_target) begin
        op_c = FN_OP_SET_TARGET;
      end else if (is_irq_en) begin
        op_c = FN_OP_SET_IRQ_EN;
      end else if (is_msg) begin
        // target still holds an unread message
        if (regs.tgt_in_pend) begin
          bresp_c = RESP_SLVERR;
        end else begin
          mem_we_c = 1'b1;
        end
      end else begin
        bresp_c = RESP_DECERR;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_EXEC) begin
      bresp_q <= bresp_c;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      notify_q <= 1'b0;
    end else if (state == ST_EXEC) begin
      notify_q <= (op_c == FN_OP_SEND) || (op_c == FN_OP_RCV);
    end
  end

  assign regs.cur_fn = fn_q;
  assign regs.op     = op_c;
  assign regs.wdata  = wdata_q;

  // message words go to the target's buffer
  assign mem.we      = mem_we_c;
  assign mem.wr_addr = '{fn: regs.cur_target, idx: msg_idx};
  assign mem.wdata   = wdata_q;

  ////////////////////////////////////////
  // bus and interrupt outputs
  assign o_s_arready = (state == ST_ADDR) & rd_q;
  assign o_s_awready = (state == ST_ADDR) & ~rd_q;
  assign o_s_wready  = (state == ST_EXEC);
  assign o_s_bvalid  = (state == ST_WR_RESP);
  assign o_s_bresp   = bresp_q;
  assign o_s_rvalid  = (state == ST_RD_RESP);
  assign o_s_rdata   = rdata_q;
  assign o_s_rresp   = rresp_q;
  assign o_irq_vld   = (state == ST_IRQ);
  assign o_irq_fn    = regs.notify_fn;

  // one transaction at a time on the slave port
  a_resp_excl: assert property (@(posedge clk) disable iff (rst)
    !(o_s_rvalid && o_s_bvalid));

  // event and its function held until the interrupt controller takes it
  a_irq_hold: assert property (@(posedge clk) disable iff (rst)
    o_irq_vld && !i_irq_ack |=> o_irq_vld && $stable(o_irq_fn));

endmodule

`default_nettype wire

// ==== design/mailbox_fn_regs.sv ====
/* per-function mailbox tables: pending flags, senders, targets and irq
   enables, updated by op strobes from the controller */
`timescale 1ns/1ps
`default_nettype none

module mailbox_fn_regs import mailbox_pkg::*; (
  input logic clk,
  input logic rst,
  mailbox_fn_regs_if.regs regs
);

  logic [N_FN-1:0] in_pend;
  logic [N_FN-1:0] out_pend;
  logic [N_FN-1:0] irq_en;
  fn_t             sender [N_FN];
  fn_t             target [N_FN];
  fn_t             cur_tgt;
  fn_t             cur_sender;

  ////////////////////////////////////////
  // views for the current caller
  assign cur_tgt    = target[regs.cur_fn];
  assign cur_sender = sender[regs.cur_fn];

  assign regs.cur_in_pend  = in_pend[regs.cur_fn];
  assign regs.cur_out_pend = out_pend[regs.cur_fn];
  assign regs.cur_target   = cur_tgt;
  assign regs.cur_irq_en   = irq_en[regs.cur_fn];
  assign regs.tgt_in_pend  = in_pend[cur_tgt];

  ////////////////////////////////////////
  // table updates
  always_ff @(posedge clk) begin
    if (rst) begin
      in_pend  <= '0;
      out_pend <= '0;
      irq_en   <= '0;
      for (int i = 0; i < N_FN; i++) begin
        sender[i] <= '0;
        target[i] <= '0;
      end
    end else begin
      case (regs.op)
        FN_OP_SEND: begin
          in_pend[cur_tgt]        <= 1'b1;
          out_pend[regs.cur_fn]   <= 1'b1;
          sender[cur_tgt]         <= regs.cur_fn;
        end
        FN_OP_RCV: begin
          in_pend[regs.cur_fn]    <= 1'b0;
          out_pend[cur_sender]    <= 1'b0;
        end
        FN_OP_SET_TARGET: target[regs.cur_fn] <= regs.wdata[FN_W-1:0];
        FN_OP_SET_IRQ_EN: irq_en[regs.cur_fn] <= regs.wdata[0];
        default: ;
      endcase
    end
  end

  // target after SEND, original sender after RCV
  always_ff @(posedge clk) begin
    if (rst) begin
      regs.notify_en <= 1'b0;
      regs.notify_fn <= '0;
    end else if (regs.op == FN_OP_SEND) begin
      regs.notify_en <= irq_en[cur_tgt];
      regs.notify_fn <= cur_tgt;
    end else if (regs.op == FN_OP_RCV) begin
      regs.notify_en <= irq_en[cur_sender];
      regs.notify_fn <= cur_sender;
    end
  end

  // controller must refuse a SEND to a busy target
  a_send_free: assert property (@(posedge clk) disable iff (rst)
    regs.op == FN_OP_SEND |-> !regs.tgt_in_pend);

endmodule

`default_nettype wire

// ==== design/mailbox_ifs.sv ====
/* bundles between the mailbox controller and its two datapath blocks,
   the message memory and the per-function tables */
`timescale 1ns/1ps
`default_nettype none

// message memory port, read data returns MEM_RD_LATENCY cycles after re
interface mailbox_msg_mem_if import mailbox_pkg::*; ();
  logic      re;
  msg_addr_t rd_addr;
  logic      we;
  msg_addr_t wr_addr;
  data_t     wdata;
  data_t     rdata;
  logic      rvalid;

  modport ctrl (output re, rd_addr, we, wr_addr, wdata, input rdata, rvalid);
  modport ram  (input re, rd_addr, we, wr_addr, wdata, output rdata, rvalid);
endinterface

// table access for the current caller
interface mailbox_fn_regs_if import mailbox_pkg::*; ();
  fn_t    cur_fn;
  fn_op_e op;
  data_t  wdata;
  logic   cur_in_pend;
  logic   cur_out_pend;
  fn_t    cur_target;
  logic   cur_irq_en;
  logic   tgt_in_pend;
  // registered when a SEND or RCV is applied
  logic   notify_en;
  fn_t    notify_fn;

  modport ctrl (output cur_fn, op, wdata,
                input  cur_in_pend, cur_out_pend, cur_target, cur_irq_en,
                       tgt_in_pend, notify_en, notify_fn);
  modport regs (input  cur_fn, op, wdata,
                output cur_in_pend, cur_out_pend, cur_target, cur_irq_en,
                       tgt_in_pend, notify_en, notify_fn);
endinterface

`default_nettype wire

// ==== design/mailbox_msg_ram.sv ====
/* message buffer memory, one MSG_WORDS buffer per function; reads return
   through a MEM_RD_LATENCY stage pipeline with a matching valid */
`timescale 1ns/1ps
`default_nettype none

module mailbox_msg_ram import mailbox_pkg::*; (
  input logic clk,
  input logic rst,
  mailbox_msg_mem_if.ram mem
);

  data_t                     ram_q [N_FN*MSG_WORDS];
  data_t                     rd_pipe [MEM_RD_LATENCY];
  logic [MEM_RD_LATENCY-1:0] vld_pipe;

  always_ff @(posedge clk) begin
    if (mem.we) begin
      ram_q[{mem.wr_addr.fn, mem.wr_addr.idx}] <= mem.wdata;
    end
  end

  ////////////////////////////////////////
  // read pipeline
  always_ff @(posedge clk) begin
    if (mem.re) begin
      rd_pipe[0] <= ram_q[{mem.rd_addr.fn, mem.rd_addr.idx}];
    end
    for (int i = 1; i < MEM_RD_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  // valid tracks each read, several may be in flight
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= (vld_pipe << 1) | MEM_RD_LATENCY'(mem.re);
    end
  end

  assign mem.rdata  = rd_pipe[MEM_RD_LATENCY-1];
  assign mem.rvalid = vld_pipe[MEM_RD_LATENCY-1];

endmodule

`default_nettype wire

// ==== design/mailbox_pkg.sv ====
/* sizes, address map, command and response codes shared by the mailbox RTL
   and its testbench; modules pull it in with a wildcard import */
`default_nettype none

package mailbox_pkg;

  ////////////////////////////////////////
  // function space
  localparam int N_FN = 8;
  localparam int FN_W = 3;
  typedef logic [FN_W-1:0] fn_t;

  // bus widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;

  ////////////////////////////////////////
  // message buffers, one per function
  localparam int MSG_WORDS      = 16;
  localparam int MSG_IDX_W      = 4;
  localparam int MEM_RD_LATENCY = 2;

  // word location in the message memory
  typedef struct packed {
    fn_t                  fn;
    logic [MSG_IDX_W-1:0] idx;
  } msg_addr_t;

  ////////////////////////////////////////
  // register map, byte addresses
  localparam addr_t STATUS_A   = 8'h00;
  localparam addr_t CMD_A      = 8'h04;
  localparam addr_t TARGET_A   = 8'h08;
  localparam addr_t IRQ_EN_A   = 8'h0C;
  // message words run from here through 0x7F
  localparam addr_t MSG_BASE_A = 8'h40;

  typedef enum logic [3:0] {
    CMD_SEND = 4'd1,
    CMD_RCV  = 4'd2
  } cmd_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  // table update requested by the controller
  typedef enum logic [2:0] {
    FN_OP_NONE,
    FN_OP_SEND,
    FN_OP_RCV,
    FN_OP_SET_TARGET,
    FN_OP_SET_IRQ_EN
  } fn_op_e;

endpackage

`default_nettype wire

// ==== design/mailbox_top.sv ====
/* mailbox top level; plain AXI4-Lite style slave port plus the interrupt
   event, wired into the controller, function tables and message memory */
`timescale 1ns/1ps
`default_nettype none

module mailbox_top import mailbox_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  // write address
  input  logic  i_s_awvalid,
  output logic  o_s_awready,
  input  addr_t i_s_awaddr,
  input  fn_t   i_s_awuser,
  // write data
  input  logic  i_s_wvalid,
  output logic  o_s_wready,
  input  data_t i_s_wdata,
  // write response
  output logic  o_s_bvalid,
  input  logic  i_s_bready,
  output resp_e o_s_bresp,
  // read address
  input  logic  i_s_arvalid,
  output logic  o_s_arready,
  input  addr_t i_s_araddr,
  input  fn_t   i_s_aruser,
  // read data
  output logic  o_s_rvalid,
  input  logic  i_s_rready,
  output data_t o_s_rdata,
  output resp_e o_s_rresp,
  // interrupt event
  output logic  o_irq_vld,
  output fn_t   o_irq_fn,
  input  logic  i_irq_ack
);

  mailbox_msg_mem_if u_mem_if ();
  mailbox_fn_regs_if u_regs_if ();

  mailbox_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .i_s_awvalid (i_s_awvalid),
    .o_s_awready (o_s_awready),
    .i_s_awaddr  (i_s_awaddr),
    .i_s_awuser  (i_s_awuser),
    .i_s_wvalid  (i_s_wvalid),
    .o_s_wready  (o_s_wready),
    .i_s_wdata   (i_s_wdata),
    .o_s_bvalid  (o_s_bvalid),
    .i_s_bready  (i_s_bready),
    .o_s_bresp   (o_s_bresp),
    .i_s_arvalid (i_s_arvalid),
    .o_s_arready (o_s_arready),
    .i_s_araddr  (i_s_araddr),
    .i_s_aruser  (i_s_aruser),
    .o_s_rvalid  (o_s_rvalid),
    .i_s_rready  (i_s_rready),
    .o_s_rdata   (o_s_rdata),
    .o_s_rresp   (o_s_rresp),
    .mem         (u_mem_if.ctrl),
    .regs        (u_regs_if.ctrl),
    .o_irq_vld   (o_irq_vld),
    .o_irq_fn    (o_irq_fn),
    .i_irq_ack   (i_irq_ack)
  );

  mailbox_fn_regs u_fn_regs (
    .clk  (clk),
    .rst  (rst),
    .regs (u_regs_if.regs)
  );

  mailbox_msg_ram u_msg_ram (
    .clk (clk),
    .rst (rst),
    .mem (u_mem_if.ram)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
design/mailbox_pkg.sv
design/mailbox_ifs.sv
design/mailbox_msg_ram.sv
design/mailbox_fn_regs.sv
design/mailbox_ctrl.sv
design/mailbox_top.sv
testbench/tb_clkgen.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// ==== testbench/tb_checker.sv ====
/* mailbox reference model; follows the handshakes at the DUT ports and
   compares responses and interrupt events against the model */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import mailbox_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  i_awvalid,
  input  logic  i_awready,
  input  addr_t i_awaddr,
  input  fn_t   i_awuser,
  input  logic  i_wvalid,
  input  logic  i_wready,
  input  data_t i_wdata,
  input  logic  i_bvalid,
  input  logic  i_bready,
  input  resp_e i_bresp,
  input  logic  i_arvalid,
  input  logic  i_arready,
  input  addr_t i_araddr,
  input  fn_t   i_aruser,
  input  logic  i_rvalid,
  input  logic  i_rready,
  input  data_t i_rdata,
  input  resp_e i_rresp,
  input  logic  i_irq_vld,
  input  fn_t   i_irq_fn,
  input  logic  i_irq_ack,
  output int    o_err_cnt,
  output int    o_chk_cnt
);

  logic [N_FN-1:0] in_pend;
  logic [N_FN-1:0] out_pend;
  logic [N_FN-1:0] irq_en;
  fn_t             sender [N_FN];
  fn_t             target [N_FN];
  data_t           msg_mem [N_FN][MSG_WORDS];
  // words never written have no known value
  logic            msg_known [N_FN][MSG_WORDS];
  addr_t           aw_addr;
  fn_t             aw_fn;
  addr_t           ar_addr;
  fn_t             ar_fn;
  resp_e           bresp_exp;
  logic            notify_exp;
  fn_t             notify_fn_exp;
  logic            irq_exp;
  fn_t             irq_fn_exp;
  logic            irq_vld_q;
  logic            rst_seen = 1'b0;
  int              err_cnt = 0;
  int              chk_cnt = 0;

  assign o_err_cnt = err_cnt;
  assign o_chk_cnt = chk_cnt;

  task automatic check_val(input string name, input data_t exp, input data_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
    end
  endtask

  function automatic logic is_msg_addr(input addr_t a);
    return (a >= MSG_BASE_A) && (a < MSG_BASE_A + addr_t'(4 * MSG_WORDS)) &&
           (a[1:0] == 2'b00);
  endfunction

  task automatic model_reset();
    in_pend    = '0;
    out_pend   = '0;
    irq_en     = '0;
    notify_exp = 1'b0;
    irq_exp    = 1'b0;
    irq_vld_q  = 1'b0;
    for (int f = 0; f < N_FN; f++) begin
      sender[f] = '0;
      target[f] = '0;
      for (int w = 0; w < MSG_WORDS; w++) begin
        msg_known[f][w] = 1'b0;
      end
    end
  endtask

  // control outputs stay low while reset is applied
  task automatic check_idle_outputs();
    check_val("o_s_awready", 32'd0, data_t'(i_awready));
    check_val("o_s_wready", 32'd0, data_t'(i_wready));
    check_val("o_s_arready", 32'd0, data_t'(i_arready));
    check_val("o_s_rvalid", 32'd0, data_t'(i_rvalid));
    check_val("o_s_bvalid", 32'd0, data_t'(i_bvalid));
    check_val("o_irq_vld", 32'd0, data_t'(i_irq_vld));
  endtask

  ////////////////////////////////////////
  // write side of the model
  task automatic apply_write(input addr_t a, input fn_t fn, input data_t d);
    fn_t                  t;
    fn_t                  s;
    logic [MSG_IDX_W-1:0] idx;
    t          = target[fn];
    s          = sender[fn];
    idx        = a[MSG_IDX_W+1:2];
    notify_exp = 1'b0;
    bresp_exp  = RESP_OKAY;
    if (a == CMD_A) begin
      if (d[3:0] == CMD_SEND && !in_pend[t]) begin
        in_pend[t]    = 1'b1;
        out_pend[fn]  = 1'b1;
        sender[t]     = fn;
        notify_exp    = irq_en[t];
        notify_fn_exp = t;
      end else if (d[3:0] == CMD_RCV && in_pend[fn]) begin
        in_pend[fn]   = 1'b0;
        out_pend[s]   = 1'b0;
        notify_exp    = irq_en[s];
        notify_fn_exp = s;
      end else begin
        bresp_exp = RESP_SLVERR;
      end
    end else if (a == TARGET_A) begin
      target[fn] = d[FN_W-1:0];
    end else if (a == IRQ_EN_A) begin
      irq_en[fn] = d[0];
    end else if (is_msg_addr(a)) begin
      // an unread message in the target buffer blocks the write
      if (in_pend[t]) begin
        bresp_exp = RESP_SLVERR;
      end else begin
        msg_mem[t][idx]   = d;
        msg_known[t][idx] = 1'b1;
      end
    end else begin
      bresp_exp = RESP_DECERR;
    end
  endtask

  task automatic check_read(input addr_t a, input fn_t fn);
    data_t                exp_d;
    resp_e                exp_r;
    logic                 cmp_d;
    logic [MSG_IDX_W-1:0] idx;
    exp_d = '0;
    exp_r = RESP_OKAY;
    cmp_d = 1'b1;
    idx   = a[MSG_IDX_W+1:2];
    if (a == STATUS_A) begin
      exp_d = 32'({out_pend[fn], in_pend[fn]});
    end else if (a == TARGET_A) begin
      exp_d = 32'(target[fn]);
    end else if (a == IRQ_EN_A) begin
      exp_d = 32'(irq_en[fn]);
    end else if (is_msg_addr(a)) begin
      if (in_pend[fn]) begin
        exp_d = msg_mem[fn][idx];
        cmp_d = msg_known[fn][idx];
      end
    end else begin
      exp_r = RESP_DECERR;
    end
    if (cmp_d) begin
      check_val("o_s_rdata", exp_d, i_rdata);
    end
    check_val("o_s_rresp", data_t'(exp_r), data_t'(i_rresp));
  endtask

  ////////////////////////////////////////
  // sampled on the rising edge before the DUT updates
  always @(posedge clk) begin
    if (rst) begin
      if (rst_seen) begin
        check_idle_outputs();
      end
      rst_seen = 1'b1;
      model_reset();
    end else begin
      if (i_irq_vld && !irq_vld_q) begin
        if (irq_exp) begin
          check_val("o_irq_fn", data_t'(irq_fn_exp), data_t'(i_irq_fn));
        end else begin
          check_val("o_irq_vld", 32'd0, 32'd1);
        end
      end
      if (i_irq_vld && i_irq_ack) begin
        irq_exp = 1'b0;
      end
      if (irq_exp && ((i_awvalid && i_awready) || (i_arvalid && i_arready))) begin
        err_cnt++;
        $display("at %0t ns: interrupt event for function %0d missing before next transaction",
                 $time, irq_fn_exp);
        irq_exp = 1'b0;
      end
      if (i_awvalid && i_awready) begin
        aw_addr = i_awaddr;
        aw_fn   = i_awuser;
      end
      if (i_wvalid && i_wready) begin
        apply_write(aw_addr, aw_fn, i_wdata);
      end
      if (i_bvalid && i_bready) begin
        check_val("o_s_bresp", data_t'(bresp_exp), data_t'(i_bresp));
        if (notify_exp) begin
          irq_exp    = 1'b1;
          irq_fn_exp = notify_fn_exp;
        end
      end
      if (i_arvalid && i_arready) begin
        ar_addr = i_araddr;
        ar_fn   = i_aruser;
      end
      if (i_rvalid && i_rready) begin
        check_read(ar_addr, ar_fn);
      end
      irq_vld_q = i_irq_vld;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_clkgen.sv ====
/* testbench clock and reset; 4 ns clock, reset held over the first two
   rising edges */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  // released on a falling edge like every other input
  initial begin
    o_rst = 1'b1;
    repeat (2) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_top.sv ====
/* mailbox testbench top; drives random reads and writes on falling edges
   and leaves all comparing to tb_checker */
`timescale 1ns/1ps
`default_nettype none

module tb_top import mailbox_pkg::*; ();

  localparam int          WAIT_LIMIT = 64;
  localparam int          N_TXN      = 1200;
  localparam logic [15:0] SEED       = 16'd19187;

  typedef enum int {AWREADY, WREADY, BVALID, ARREADY, RVALID} wait_e;

  logic        clk;
  logic        rst;
  logic        i_s_awvalid;
  logic        o_s_awready;
  addr_t       i_s_awaddr;
  fn_t         i_s_awuser;
  logic        i_s_wvalid;
  logic        o_s_wready;
  data_t       i_s_wdata;
  logic        o_s_bvalid;
  logic        i_s_bready;
  resp_e       o_s_bresp;
  logic        i_s_arvalid;
  logic        o_s_arready;
  addr_t       i_s_araddr;
  fn_t         i_s_aruser;
  logic        o_s_rvalid;
  logic        i_s_rready;
  data_t       o_s_rdata;
  resp_e       o_s_rresp;
  logic        o_irq_vld;
  fn_t         o_irq_fn;
  logic        i_irq_ack;
  logic [15:0] lfsr_q;
  int          timeouts;
  int          err_cnt;
  int          chk_cnt;

  tb_clkgen u_clkgen (
    .o_clk (clk),
    .o_rst (rst)
  );

  mailbox_top u_mailbox_top (.*);

  tb_checker u_checker (
    .clk       (clk),
    .rst       (rst),
    .i_awvalid (i_s_awvalid),
    .i_awready (o_s_awready),
    .i_awaddr  (i_s_awaddr),
    .i_awuser  (i_s_awuser),
    .i_wvalid  (i_s_wvalid),
    .i_wready  (o_s_wready),
    .i_wdata   (i_s_wdata),
    .i_bvalid  (o_s_bvalid),
    .i_bready  (i_s_bready),
    .i_bresp   (o_s_bresp),
    .i_arvalid (i_s_arvalid),
    .i_arready (o_s_arready),
    .i_araddr  (i_s_araddr),
    .i_aruser  (i_s_aruser),
    .i_rvalid  (o_s_rvalid),
    .i_rready  (i_s_rready),
    .i_rdata   (o_s_rdata),
    .i_rresp   (o_s_rresp),
    .i_irq_vld (o_irq_vld),
    .i_irq_fn  (o_irq_fn),
    .i_irq_ack (i_irq_ack),
    .o_err_cnt (err_cnt),
    .o_chk_cnt (chk_cnt)
  );

  ////////////////////////////////////////
  // 16 bit Galois LFSR for random numbers
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  function automatic logic out_level(input wait_e sel);
    case (sel)
      AWREADY: return o_s_awready;
      WREADY:  return o_s_wready;
      BVALID:  return o_s_bvalid;
      ARREADY: return o_s_arready;
      default: return o_s_rvalid;
    endcase
  endfunction

  // outputs only move on rising edges, so falling edges see stable values
  task automatic wait_high(input wait_e sel);
    int n;
    n = 0;
    while (timeouts == 0 && !out_level(sel)) begin
      @(negedge clk);
      n++;
      if (n >= WAIT_LIMIT && !out_level(sel)) begin
        $display("timeout at %0t ns: %s stayed low for %0d cycles", $time, sel.name(), n);
        timeouts++;
      end
    end
  endtask

  task automatic service_irq();
    int d;
    if (o_irq_vld) begin
      d = int'(rand_bits(2));
      repeat (d) @(negedge clk);
      i_irq_ack = 1'b1;
      @(negedge clk);
      i_irq_ack = 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // bus transactions
  task automatic do_write(input addr_t addr, input fn_t fn, input data_t data);
    int d;
    i_s_awvalid = 1'b1;
    i_s_awaddr  = addr;
    i_s_awuser  = fn;
    i_s_wvalid  = 1'b1;
    i_s_wdata   = data;
    wait_high(AWREADY);
    if (timeouts != 0) return;
    @(negedge clk);
    i_s_awvalid = 1'b0;
    wait_high(WREADY);
    if (timeouts != 0) return;
    @(negedge clk);
    i_s_wvalid = 1'b0;
    wait_high(BVALID);
    if (timeouts != 0) return;
    d = int'(rand_bits(2));
    repeat (d) @(negedge clk);
    i_s_bready = 1'b1;
    @(negedge clk);
    i_s_bready = 1'b0;
    service_irq();
  endtask

  task automatic do_read(input addr_t addr, input fn_t fn);
    int d;
    i_s_arvalid = 1'b1;
    i_s_araddr  = addr;
    i_s_aruser  = fn;
    wait_high(ARREADY);
    if (timeouts != 0) return;
    @(negedge clk);
    i_s_arvalid = 1'b0;
    wait_high(RVALID);
    if (timeouts != 0) return;
    d = int'(rand_bits(2));
    repeat (d) @(negedge clk);
    i_s_rready = 1'b1;
    @(negedge clk);
    i_s_rready = 1'b0;
  endtask

  // address mix favours the command register and the message region
  task automatic random_txn();
    logic [2:0] sel;
    logic [1:0] kind;
    logic       is_rd;
    fn_t        fn;
    addr_t      addr;
    data_t      data;
    sel   = 3'(rand_bits(3));
    is_rd = 1'(rand_bits(1));
    fn    = fn_t'(rand_bits(FN_W));
    data  = rand_bits(DATA_W);
    case (sel)
      3'd0:    addr = STATUS_A;
      3'd1:    addr = CMD_A;
      3'd2:    addr = CMD_A;
      3'd3:    addr = TARGET_A;
      3'd4:    addr = IRQ_EN_A;
      3'd5:    addr = MSG_BASE_A + addr_t'(4 * rand_bits(MSG_IDX_W));
      3'd6:    addr = MSG_BASE_A + addr_t'(4 * rand_bits(MSG_IDX_W));
      default: addr = addr_t'(rand_bits(ADDR_W));
    endcase
    if (addr == CMD_A) begin
      kind = 2'(rand_bits(2));
      case (kind)
        2'd0:    data = 32'(CMD_SEND);
        2'd1:    data = 32'(CMD_SEND);
        2'd2:    data = 32'(CMD_RCV);
        default: data = 32'(rand_bits(4));
      endcase
    end
    if (is_rd) begin
      do_read(addr, fn);
    end else begin
      do_write(addr, fn, data);
    end
  endtask

  initial begin
    int n;
    i_s_awvalid = 1'b0;
    i_s_awaddr  = '0;
    i_s_awuser  = '0;
    i_s_wvalid  = 1'b0;
    i_s_wdata   = '0;
    i_s_bready  = 1'b0;
    i_s_arvalid = 1'b0;
    i_s_araddr  = '0;
    i_s_aruser  = '0;
    i_s_rready  = 1'b0;
    i_irq_ack   = 1'b0;
    lfsr_q      = SEED;
    timeouts    = 0;
    n           = 0;
    @(negedge clk);
    // reset moves on falling edges, so look at it on rising ones
    while (rst && n < WAIT_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (rst) begin
      $display("timeout at %0t ns: reset was never released", $time);
      timeouts++;
    end
    @(negedge clk);
    // every function starts with nothing pending
    for (int f = 0; f < N_FN && timeouts == 0; f++) begin
      do_read(STATUS_A, fn_t'(f));
    end
    for (int i = 0; i < N_TXN && timeouts == 0; i++) begin
      random_txn();
    end
    // a last read closes any interrupt check still open
    if (timeouts == 0) begin
      do_read(STATUS_A, '0);
    end
    repeat (4) @(negedge clk);
    $display("checks: %0d  errors: %0d  timeouts: %0d", chk_cnt, err_cnt, timeouts);
    if (err_cnt == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
